// File: addr_decode.sv
// splits the shared read and write addresses into region selects and register write strobes
`timescale 1ns/1ps

module addr_decode
    import host_bus_pkg::*;
(
    input  logic              reg_wen,      // write strobe of the granted host
    input  logic [ADDR_W-1:0] reg_raddr,    // shared read address
    input  logic [ADDR_W-1:0] reg_waddr,    // shared write address
    output logic              rd_main,      // read hits board registers
    output logic              rd_hub,       // read hits hub memory
    output logic [OFFS_W-1:0] rd_offs,      // board register being read
    output logic              ip_wen,       // write ip address register
    output logic              phy_wen,      // write phy control, starts lreq
    output logic              hub_wen       // write hub memory word
);

    reg_addr_u raddr_u;                     // read address, both views
    reg_addr_u waddr_u;                     // write address, both views
    logic      wr_main;                     // write lands in main region

    assign raddr_u = reg_raddr;
    assign waddr_u = reg_waddr;

    // ----------------------------------------------------------
    // read side
    // ----------------------------------------------------------
    // main region only when the middle byte is clear
    assign rd_main = (raddr_u.main.region == ADDR_MAIN) && (raddr_u.main.mid == '0);
    assign rd_hub  = (raddr_u.mem.region == ADDR_HUB);      // word index taken from low bits
    assign rd_offs = raddr_u.main.offs;

    // ----------------------------------------------------------
    // write side, all strobes qualified by reg_wen
    // ----------------------------------------------------------
    assign wr_main = (waddr_u.main.region == ADDR_MAIN) && (waddr_u.main.mid == '0);

    assign ip_wen  = reg_wen && wr_main && (waddr_u.main.offs == REG_IPADDR);
    assign phy_wen = reg_wen && wr_main && (waddr_u.main.offs == REG_PHYCTRL);
    assign hub_wen = reg_wen && (waddr_u.mem.region == ADDR_HUB);  // any hub offset

endmodule

// File: board_regs.sv
// board register file: ip address register, outside status words and the hub memory
`timescale 1ns/1ps

module board_regs
    import host_bus_pkg::*;
(
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic [OFFS_W-1:0] rd_offs,      // main register being read
    input  logic              ip_wen,       // ip address write strobe
    input  logic              hub_wen,      // hub memory write strobe
    input  logic [ADDR_W-1:0] reg_raddr,    // low bits index hub memory
    input  logic [ADDR_W-1:0] reg_waddr,    // low bits index hub memory
    input  logic [DATA_W-1:0] reg_wdata,
    input  logic [DATA_W-1:0] prom_status,  // from prom controller
    input  logic [DATA_W-1:0] eth_status,   // from ethernet block
    output logic [DATA_W-1:0] main_rdata,   // combinational, no wait
    output logic [DATA_W-1:0] hub_rdata,    // registered, one wait cycle
    output logic [DATA_W-1:0] ip_address    // ip address of this board
);

    logic [DATA_W-1:0] hub_mem [HUB_DEPTH];     // hub quadlets
    logic [HUB_AW-1:0] hub_raddr;               // hub read index
    logic [HUB_AW-1:0] hub_waddr;               // hub write index

    assign hub_raddr = reg_raddr[HUB_AW-1:0];
    assign hub_waddr = reg_waddr[HUB_AW-1:0];

    // ----------------------------------------------------------
    // ip address register
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ip_address <= IP_RESET;             // all ones, unassigned
        end
        else if (ip_wen)
        begin
            ip_address <= reg_wdata;
        end
    end

    // ----------------------------------------------------------
    // hub memory
    // ----------------------------------------------------------
    // read port is registered so the data lags reg_raddr by a cycle
    always_ff @(posedge sysclk)
    begin
        if (hub_wen)
        begin
            hub_mem[hub_waddr] <= reg_wdata;
        end
        hub_rdata <= hub_mem[hub_raddr];        // old word on same-address write
    end

    // ----------------------------------------------------------
    // main region read mux
    // ----------------------------------------------------------
    always_comb
    begin
        case (rd_offs)
            REG_PROMSTAT:
                main_rdata = prom_status;       // passed straight through
            REG_PROMRES:
                main_rdata = '0;                // no prom result here
            REG_IPADDR:
                main_rdata = ip_address;
            REG_ETHSTAT:
                main_rdata = eth_status;
            default:
                main_rdata = '0;                // phyctrl and unlisted offsets
        endcase
    end

endmodule

// File: bus_arbiter.sv
// registered read/write bus grants between the firewire and ethernet hosts, muxes the granted bus
`timescale 1ns/1ps

module bus_arbiter
    import host_bus_pkg::*;
(
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic              fw_req_read_bus,      // fw wants reg_raddr
    input  logic              eth_req_read_bus,     // eth wants reg_raddr
    input  logic              fw_req_write_bus,     // fw wants write bus
    input  logic              eth_req_write_bus,    // eth wants write bus
    input  logic [ADDR_W-1:0] fw_reg_raddr,
    input  logic [ADDR_W-1:0] eth_reg_raddr,
    input  logic [ADDR_W-1:0] fw_reg_waddr,
    input  logic [ADDR_W-1:0] eth_reg_waddr,
    input  logic [DATA_W-1:0] fw_reg_wdata,
    input  logic [DATA_W-1:0] eth_reg_wdata,
    input  logic              fw_reg_wen,
    input  logic              eth_reg_wen,
    output logic              fw_grant_read_bus,    // fw owns read bus
    output logic              eth_grant_read_bus,   // eth owns read bus
    output logic              fw_grant_write_bus,   // fw owns write bus
    output logic              eth_grant_write_bus,  // eth owns write bus
    output logic [ADDR_W-1:0] reg_raddr,            // shared read address
    output logic [ADDR_W-1:0] reg_waddr,            // shared write address
    output logic [DATA_W-1:0] reg_wdata,            // shared write data
    output logic              reg_wen               // shared write strobe
);

    // ----------------------------------------------------------
    // grants, one cycle behind the requests
    // ----------------------------------------------------------
    // fw wins a tie and keeps the bus while nobody asks
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fw_grant_read_bus   <= 1'b1;                // idle bus parks on fw
            eth_grant_read_bus  <= 1'b0;
            fw_grant_write_bus  <= 1'b1;
            eth_grant_write_bus <= 1'b0;
        end
        else
        begin
            fw_grant_read_bus   <= fw_req_read_bus | ~eth_req_read_bus;
            eth_grant_read_bus  <= ~fw_req_read_bus & eth_req_read_bus;
            fw_grant_write_bus  <= fw_req_write_bus | ~eth_req_write_bus;
            eth_grant_write_bus <= ~fw_req_write_bus & eth_req_write_bus;
        end
    end

    // ----------------------------------------------------------
    // bus mux, no register in the path
    // ----------------------------------------------------------
    assign reg_raddr = eth_grant_read_bus ? eth_reg_raddr : fw_reg_raddr;  // fw by default

    assign reg_waddr = eth_grant_write_bus ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_grant_write_bus ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = eth_grant_write_bus ? eth_reg_wen   : fw_reg_wen;    // strobe follows owner

endmodule

// File: flist.f
host_bus_pkg.sv
bus_arbiter.sv
addr_decode.sv
board_regs.sv
phy_request.sv
read_result.sv
host_bus_top.sv
host_bus_assert.sv
host_bus_tb.sv

// File: host_bus_assert.sv
// concurrent checks on bus ownership and read valid, bound into host_bus_top for simulation
`timescale 1ns/1ps

module host_bus_assert
    import host_bus_pkg::*;
(
    input logic              sysclk,
    input logic              arst_n,
    input logic              fw_grant_read_bus,
    input logic              eth_grant_read_bus,
    input logic              fw_grant_write_bus,
    input logic              eth_grant_write_bus,
    input logic [ADDR_W-1:0] reg_raddr,
    input logic              reg_rwait_ext,
    input logic              reg_rvalid
);

    // ------------------------------------------------------------
    // one owner per bus
    // ------------------------------------------------------------
    a_read_owner: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(fw_grant_read_bus && eth_grant_read_bus))
        else $error("both hosts hold the read bus");

    a_write_owner: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(fw_grant_write_bus && eth_grant_write_bus))
        else $error("both hosts hold the write bus");

    // board registers answer in the address cycle unless the external board waits
    a_main_valid: assert property (@(posedge sysclk) disable iff (!arst_n)
        (reg_raddr[ADDR_W-1 -: REGION_W] == ADDR_MAIN && !reg_rwait_ext) |-> reg_rvalid)
        else $error("main region read without reg_rvalid");

endmodule

bind host_bus_top host_bus_assert u_host_bus_assert (.*);

// File: host_bus_pkg.sv
// shared widths, address map, register offsets and phy request codes, imported by every host bus block
package host_bus_pkg;

    // ----------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------
    localparam int ADDR_W   = 16;                           // register address
    localparam int DATA_W   = 32;                           // register data (quadlet)
    localparam int REGION_W = 4;                            // region field, addr[15:12]
    localparam int OFFS_W   = 4;                            // board register offset, addr[3:0]

    // region codes in addr[15:12]
    localparam logic [REGION_W-1:0] ADDR_MAIN = 4'd0;       // board registers
    localparam logic [REGION_W-1:0] ADDR_HUB  = 4'd2;       // hub memory
    localparam logic [REGION_W-1:0] ADDR_PROM = 4'd3;       // prom, not mapped here
    localparam logic [REGION_W-1:0] ADDR_ETH  = 4'd4;       // ethernet, not mapped here

    // offsets inside the main region
    localparam logic [OFFS_W-1:0] REG_PHYCTRL  = 4'd1;      // phy link request trigger
    localparam logic [OFFS_W-1:0] REG_PROMSTAT = 4'd8;      // prom status, from outside
    localparam logic [OFFS_W-1:0] REG_PROMRES  = 4'd9;      // prom result, reads zero
    localparam logic [OFFS_W-1:0] REG_IPADDR   = 4'd11;     // ip address register
    localparam logic [OFFS_W-1:0] REG_ETHSTAT  = 4'd12;     // ethernet status, from outside

    // ----------------------------------------------------------
    // hub memory and phy request
    // ----------------------------------------------------------
    localparam int HUB_DEPTH    = 16;                       // quadlets in hub memory
    localparam int HUB_AW       = 4;                        // hub word index
    localparam int LREQ_TYPE_W  = 3;                        // request type field
    localparam int LREQ_DATA_W  = 12;                       // register number + value
    localparam int LREQ_FRAME_W = 1 + LREQ_TYPE_W + LREQ_DATA_W;    // start + type + data
    localparam int LREQ_CNT_W   = $clog2(LREQ_FRAME_W + 1); // bits left in frame
    localparam logic [LREQ_TYPE_W-1:0] LREQ_REG_RD = 3'd1;  // phy register read
    localparam logic [LREQ_TYPE_W-1:0] LREQ_REG_WR = 3'd5;  // phy register write
    localparam logic [DATA_W-1:0]      IP_RESET    = 32'hFFFF_FFFF; // no ip assigned

    // register address seen two ways: board register or memory word
    typedef union packed {
        struct packed {
            logic [REGION_W-1:0]               region;      // addr[15:12]
            logic [ADDR_W-REGION_W-OFFS_W-1:0] mid;         // must be zero for main
            logic [OFFS_W-1:0]                 offs;        // board register
        } main;
        struct packed {
            logic [REGION_W-1:0]        region;             // addr[15:12]
            logic [ADDR_W-REGION_W-1:0] offs;               // memory word offset
        } mem;
    } reg_addr_u;

endpackage

// File: host_bus_tb.sv
// table-driven simulation top that drives both hosts into host_bus_top and checks its outputs
`timescale 1ns/1ps

module host_bus_tb
    import host_bus_pkg::*;
();

    localparam logic [1:0]        K_WR      = 2'd0;        // register write
    localparam logic [1:0]        K_RD      = 2'd1;        // register read
    localparam logic [1:0]        K_PHY     = 2'd2;        // phy control write and frame check
    localparam int                TIMEOUT   = 20;          // cycles per wait
    localparam logic [ADDR_W-1:0] IDLE_ADDR = 16'hF000;    // unmapped address parks the read bus

    typedef struct packed {
        logic              host;        // 0 fw, 1 eth
        logic [1:0]        kind;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] ext;         // reg_rdata_ext during a read
        logic              ext_wait;    // reg_rwait_ext during a read
        logic [DATA_W-1:0] exp;         // read data or ip_address after a write
    } op_t;

    logic sysclk, arst_n;
    logic fw_req_read_bus, eth_req_read_bus, fw_req_write_bus, eth_req_write_bus;
    logic [ADDR_W-1:0] fw_reg_raddr, eth_reg_raddr, fw_reg_waddr, eth_reg_waddr;
    logic [DATA_W-1:0] fw_reg_wdata, eth_reg_wdata, reg_rdata_ext, prom_status, eth_status;
    logic fw_reg_wen, eth_reg_wen, reg_rwait_ext;
    logic fw_grant_read_bus, eth_grant_read_bus, fw_grant_write_bus, eth_grant_write_bus;
    logic [ADDR_W-1:0] reg_raddr, reg_waddr;
    logic [DATA_W-1:0] reg_wdata, reg_rdata, ip_address;
    logic reg_wen, reg_rvalid, lreq;

    op_t ops [$];                               // operation table
    int  data_errs, addr_errs, flag_errs, frame_errs, timeouts;

    host_bus_top u_host_bus_top (.*);

    always #2 sysclk = ~sysclk;                 // 4 ns period

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            data_errs++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_W-1:0] got,
                                input logic [ADDR_W-1:0] exp);
        if (got !== exp)
        begin
            addr_errs++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errs++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_frame_bit(input int idx, input logic got, input logic exp);
        if (got !== exp)
        begin
            frame_errs++;
            $display("** Error at %0t: lreq bit %0d got %b expected %b", $time, idx, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // host drivers
    // ------------------------------------------------------------
    task automatic set_request(input logic host, input logic is_write, input logic val);
        case ({host, is_write})
            2'b00:   fw_req_read_bus   <= val;
            2'b01:   fw_req_write_bus  <= val;
            2'b10:   eth_req_read_bus  <= val;
            default: eth_req_write_bus <= val;
        endcase
    endtask

    function automatic logic has_grant(input logic host, input logic is_write);
        case ({host, is_write})
            2'b00:   return fw_grant_read_bus;
            2'b01:   return fw_grant_write_bus;
            2'b10:   return eth_grant_read_bus;
            default: return eth_grant_write_bus;
        endcase
    endfunction

    task automatic drive_raddr(input logic host, input logic [ADDR_W-1:0] addr);
        if (host)
            eth_reg_raddr <= addr;
        else
            fw_reg_raddr <= addr;
    endtask

    task automatic drive_write(input logic host, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic wen);
        if (host)
        begin
            eth_reg_waddr <= addr;
            eth_reg_wdata <= data;
            eth_reg_wen   <= wen;
        end
        else
        begin
            fw_reg_waddr <= addr;
            fw_reg_wdata <= data;
            fw_reg_wen   <= wen;
        end
    endtask

    task automatic acquire_bus(input logic host, input logic is_write);
        int n;
        n = 0;
        @(posedge sysclk);
        set_request(host, is_write, 1'b1);
        @(negedge sysclk);
        while (!has_grant(host, is_write) && n < TIMEOUT)
        begin
            @(negedge sysclk);
            n++;
        end
        if (!has_grant(host, is_write))
        begin
            timeouts++;
            $display("timeout: host %0d was never granted the bus (write %0b)", host, is_write);
        end
    endtask

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    task automatic write_register(input op_t op);
        acquire_bus(op.host, 1'b1);
        @(posedge sysclk);
        drive_write(op.host, op.addr, op.data, 1'b1);   // write lands on the next edge
        @(negedge sysclk);
        compare_flag("reg_wen", reg_wen, 1'b1);         // granted host on the shared bus
        compare_addr("reg_waddr", reg_waddr, op.addr);
        compare_data("reg_wdata", reg_wdata, op.data);
        @(posedge sysclk);
        drive_write(op.host, op.addr, op.data, 1'b0);
        set_request(op.host, 1'b1, 1'b0);
        @(negedge sysclk);
        compare_flag("reg_wen", reg_wen, 1'b0);
        if (op.addr == 16'h000B)
            compare_data("ip_address", ip_address, op.exp);
    endtask

    task automatic read_register(input op_t op);
        int   n;
        logic exp_wait;
        n        = 0;
        exp_wait = (op.addr[15:12] == ADDR_HUB) || op.ext_wait;    // hub or external wait
        acquire_bus(op.host, 1'b0);
        @(posedge sysclk);
        drive_raddr(op.host, op.addr);
        reg_rdata_ext <= op.ext;
        reg_rwait_ext <= op.ext_wait;
        @(negedge sysclk);
        compare_addr("reg_raddr", reg_raddr, op.addr);
        compare_flag("reg_rvalid", reg_rvalid, !exp_wait);  // first address cycle
        while (!reg_rvalid && n < TIMEOUT)
        begin
            @(negedge sysclk);
            n++;
        end
        if (reg_rvalid)
            compare_data("reg_rdata", reg_rdata, op.exp);
        else
        begin
            timeouts++;
            $display("timeout: reg_rvalid never rose for address %h", op.addr);
        end
        @(posedge sysclk);
        drive_raddr(op.host, IDLE_ADDR);
        reg_rdata_ext <= 32'h0;
        reg_rwait_ext <= 1'b0;
        set_request(op.host, 1'b0, 1'b0);
    endtask

    task automatic send_phy_request(input op_t op);
        logic [15:0] frame;
        int          n;
        int          i;
        frame = {1'b1, op.data[12] ? LREQ_REG_WR : LREQ_REG_RD, op.data[11:0]};
        n     = 0;
        acquire_bus(op.host, 1'b1);
        @(posedge sysclk);
        drive_write(op.host, 16'h0001, op.data, 1'b1);
        @(posedge sysclk);
        drive_write(op.host, 16'h0001, op.data, 1'b0);
        @(negedge sysclk);
        while (!lreq && n < TIMEOUT)
        begin
            @(negedge sysclk);
            n++;
        end
        if (!lreq)
        begin
            timeouts++;
            $display("timeout: no start bit on lreq");
        end
        compare_flag("lreq start in next cycle", n == 0, 1'b1);
        for (i = 15; i >= 0; i--)
        begin
            compare_frame_bit(i, lreq, frame[i]);
            @(posedge sysclk);
            drive_write(op.host, 16'h0001, ~op.data, i == 10);  // retrigger mid frame
            @(negedge sysclk);
        end
        compare_flag("lreq after frame", lreq, 1'b0);
        @(posedge sysclk);
        set_request(op.host, 1'b1, 1'b0);
    endtask

    task automatic check_arbitration();
        @(negedge sysclk);
        compare_flag("fw_grant_read_bus", fw_grant_read_bus, 1'b1);    // parked on fw
        compare_flag("fw_grant_write_bus", fw_grant_write_bus, 1'b1);
        compare_flag("eth_grant_read_bus", eth_grant_read_bus, 1'b0);
        compare_flag("eth_grant_write_bus", eth_grant_write_bus, 1'b0);
        @(posedge sysclk);
        eth_req_read_bus  <= 1'b1;
        eth_req_write_bus <= 1'b1;
        @(negedge sysclk);
        compare_flag("eth_grant_read_bus", eth_grant_read_bus, 1'b0);  // not yet
        @(negedge sysclk);
        compare_flag("eth_grant_read_bus", eth_grant_read_bus, 1'b1);
        compare_flag("eth_grant_write_bus", eth_grant_write_bus, 1'b1);
        compare_flag("fw_grant_read_bus", fw_grant_read_bus, 1'b0);
        @(posedge sysclk);
        fw_req_read_bus  <= 1'b1;                   // both ask and fw wins
        fw_req_write_bus <= 1'b1;
        @(negedge sysclk);
        @(negedge sysclk);
        compare_flag("fw_grant_read_bus", fw_grant_read_bus, 1'b1);
        compare_flag("eth_grant_read_bus", eth_grant_read_bus, 1'b0);
        compare_flag("fw_grant_write_bus", fw_grant_write_bus, 1'b1);
        compare_flag("eth_grant_write_bus", eth_grant_write_bus, 1'b0);
        @(posedge sysclk);
        {fw_req_read_bus, fw_req_write_bus, eth_req_read_bus, eth_req_write_bus} <= 4'b0;
    endtask

    task automatic add_op(input logic host, input logic [1:0] kind,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [DATA_W-1:0] ext, input logic ext_wait,
                          input logic [DATA_W-1:0] exp);
        op_t op;
        op = '{host, kind, addr, data, ext, ext_wait, exp};
        ops.push_back(op);
    endtask

    // ------------------------------------------------------------
    // table of operations with expected values from the register map
    // ------------------------------------------------------------
    task automatic build_table();
        logic [DATA_W-1:0] hub_model [HUB_DEPTH];
        logic [HUB_AW-1:0] hub_idx [6];
        logic [DATA_W-1:0] ip_exp;
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] x;
        int                i;
        add_op(1'b0, K_RD, 16'h000B, 32'h0, 32'h0, 1'b0, 32'hFFFF_FFFF);   // ip after reset
        ip_exp = $urandom();
        add_op(1'b0, K_WR, 16'h000B, ip_exp, 32'h0, 1'b0, ip_exp);
        add_op(1'b1, K_RD, 16'h000B, 32'h0, 32'h0, 1'b0, ip_exp);
        ip_exp = $urandom();
        add_op(1'b1, K_WR, 16'h000B, ip_exp, 32'h0, 1'b0, ip_exp);
        add_op(1'b0, K_RD, 16'h000B, 32'h0, 32'h0, 1'b0, ip_exp);
        add_op(1'b0, K_RD, 16'h0008, 32'h0, 32'h0, 1'b0, prom_status);
        add_op(1'b1, K_RD, 16'h000C, 32'h0, 32'h0, 1'b0, eth_status);
        x = $urandom();
        add_op(1'b0, K_RD, 16'h0009, 32'h0, x, 1'b0, x);          // prom result is zero
        add_op(1'b1, K_RD, 16'h0005, 32'h0, x, 1'b0, x);          // unlisted offset
        add_op(1'b0, K_RD, 16'h0108, 32'h0, x, 1'b0, x);          // middle field set
        add_op(1'b1, K_RD, 16'h3008, 32'h0, x, 1'b0, x);          // prom region unmapped
        add_op(1'b0, K_RD, 16'h4000, 32'h0, 32'h0, 1'b0, 32'h0);  // eth region unmapped
        for (i = 0; i < 6; i++)
        begin
            hub_idx[i] = (i == 3) ? hub_idx[0] : HUB_AW'($urandom());  // 3 overwrites 0
            w = $urandom();
            hub_model[hub_idx[i]] = w;
            add_op(i[0], K_WR, {12'h200, hub_idx[i]}, w, 32'h0, 1'b0, 32'h0);
        end
        for (i = 0; i < 6; i++)
            add_op(~i[0], K_RD, {12'h200, hub_idx[i]}, 32'h0, 32'h0, 1'b0,
                   hub_model[hub_idx[i]]);
        x = $urandom();
        add_op(1'b1, K_RD, 16'h000C, 32'h0, x, 1'b1, eth_status | x);  // external wait
        add_op(1'b0, K_RD, 16'h000B, 32'h0, x, 1'b1, ip_exp | x);
        add_op(1'b0, K_RD, {12'h200, hub_idx[1]}, 32'h0, x, 1'b1, hub_model[hub_idx[1]] | x);
        w = $urandom();
        add_op(1'b0, K_PHY, 16'h0001, w | 32'h0000_1000, 32'h0, 1'b0, 32'h0);    // write type
        add_op(1'b1, K_PHY, 16'h0001, w & ~32'h0000_1000, 32'h0, 1'b0, 32'h0);   // read type
    endtask

    initial
    begin
        void'($urandom(32'h9492));
        sysclk = 1'b0;
        arst_n = 1'b0;
        {fw_req_read_bus, fw_req_write_bus, eth_req_read_bus, eth_req_write_bus} = 4'b0;
        fw_reg_raddr  = IDLE_ADDR;
        eth_reg_raddr = IDLE_ADDR;
        fw_reg_waddr  = 16'h0;
        eth_reg_waddr = 16'h0;
        fw_reg_wdata  = 32'h0;
        eth_reg_wdata = 32'h0;
        fw_reg_wen    = 1'b0;
        eth_reg_wen   = 1'b0;
        reg_rdata_ext = 32'h0;
        reg_rwait_ext = 1'b0;
        prom_status   = $urandom();
        eth_status    = $urandom();
        build_table();
        repeat (3) @(posedge sysclk);
        arst_n <= 1'b1;
        check_arbitration();
        foreach (ops[i])
        begin
            case (ops[i].kind)
                K_WR:    write_register(ops[i]);
                K_RD:    read_register(ops[i]);
                default: send_phy_request(ops[i]);
            endcase
        end
        repeat (2) @(posedge sysclk);
        $display("errors: data %0d, addr %0d, flags %0d, frame bits %0d, timeouts %0d",
                 data_errs, addr_errs, flag_errs, frame_errs, timeouts);
        if (data_errs + addr_errs + flag_errs + frame_errs + timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: host_bus_top.sv
// top of the host register bus: arbiter, decode, board registers, phy request and read result
`timescale 1ns/1ps

module host_bus_top
    import host_bus_pkg::*;
(
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic              fw_req_read_bus,
    input  logic              eth_req_read_bus,
    input  logic              fw_req_write_bus,
    input  logic              eth_req_write_bus,
    input  logic [ADDR_W-1:0] fw_reg_raddr,
    input  logic [ADDR_W-1:0] eth_reg_raddr,
    input  logic [ADDR_W-1:0] fw_reg_waddr,
    input  logic [ADDR_W-1:0] eth_reg_waddr,
    input  logic [DATA_W-1:0] fw_reg_wdata,
    input  logic [DATA_W-1:0] eth_reg_wdata,
    input  logic              fw_reg_wen,
    input  logic              eth_reg_wen,
    input  logic [DATA_W-1:0] reg_rdata_ext,    // external board read data
    input  logic              reg_rwait_ext,    // external board wait flag
    input  logic [DATA_W-1:0] prom_status,
    input  logic [DATA_W-1:0] eth_status,
    output logic              fw_grant_read_bus,
    output logic              eth_grant_read_bus,
    output logic              fw_grant_write_bus,
    output logic              eth_grant_write_bus,
    output logic [ADDR_W-1:0] reg_raddr,
    output logic [ADDR_W-1:0] reg_waddr,
    output logic [DATA_W-1:0] reg_wdata,
    output logic [DATA_W-1:0] reg_rdata,
    output logic              reg_wen,
    output logic              reg_rvalid,
    output logic [DATA_W-1:0] ip_address,
    output logic              lreq              // phy link request line
);

    // ----------------------------------------------------------
    // decode and register wires
    // ----------------------------------------------------------
    logic              rd_main;         // read in main region
    logic              rd_hub;          // read in hub region
    logic [OFFS_W-1:0] rd_offs;         // main register offset
    logic              ip_wen;          // ip register strobe
    logic              phy_wen;         // phy request trigger
    logic              hub_wen;         // hub memory strobe
    logic [DATA_W-1:0] main_rdata;      // board register word
    logic [DATA_W-1:0] hub_rdata;       // hub memory word

    bus_arbiter u_bus_arbiter (.*);     // grants and shared bus

    addr_decode u_addr_decode (.*);     // selects and strobes

    board_regs u_board_regs (.*);       // ip, status, hub memory

    phy_request u_phy_request (.*);     // lreq frame

    read_result u_read_result (.*);     // rdata and rvalid

endmodule

// File: phy_request.sv
// sends a 16-bit phy link request frame on lreq after a write to the phy control register
`timescale 1ns/1ps

module phy_request
    import host_bus_pkg::*;
(
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic              phy_wen,      // trigger from phy control write
    input  logic [DATA_W-1:0] reg_wdata,    // bit 12 picks type, 11:0 is payload
    output logic              lreq          // serial request to the phy
);

    logic [LREQ_FRAME_W-1:0] frame_sr;      // frame being shifted out, msb first
    logic [LREQ_CNT_W-1:0]   bit_cnt;       // bits still to send
    logic [LREQ_TYPE_W-1:0]  req_type;      // read or write request
    logic                    busy;          // frame on the line

    assign busy     = (bit_cnt != '0);
    assign req_type = reg_wdata[LREQ_DATA_W] ? LREQ_REG_WR : LREQ_REG_RD;

    // ----------------------------------------------------------
    // load and shift
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame_sr <= '0;                     // keeps lreq low
            bit_cnt  <= '0;
        end
        else if (phy_wen && !busy)
        begin
            // start bit, type, then register data
            frame_sr <= {1'b1, req_type, reg_wdata[LREQ_DATA_W-1:0]};
            bit_cnt  <= LREQ_CNT_W'(LREQ_FRAME_W);
        end
        else if (busy)
        begin
            frame_sr <= {frame_sr[LREQ_FRAME_W-2:0], 1'b0};   // zeros fill in behind
            bit_cnt  <= bit_cnt - 1'b1;
        end
    end

    // all zero once the last bit has left
    assign lreq = frame_sr[LREQ_FRAME_W-1];

endmodule

// File: read_result.sv
// routes region read data onto reg_rdata, merges the external board, and flags when it is valid
`timescale 1ns/1ps

module read_result
    import host_bus_pkg::*;
(
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic              rd_main,          // board register read
    input  logic              rd_hub,           // hub memory read
    input  logic [DATA_W-1:0] main_rdata,
    input  logic [DATA_W-1:0] hub_rdata,
    input  logic [DATA_W-1:0] reg_rdata_ext,    // data from external board
    input  logic              reg_rwait_ext,    // external board needs a wait cycle
    input  logic [ADDR_W-1:0] reg_raddr,
    output logic [DATA_W-1:0] reg_rdata,        // merged read data
    output logic              reg_rvalid        // reg_rdata can be taken
);

    logic [DATA_W-1:0] int_rdata;       // data from this fpga
    logic              int_rwait;       // wait flag from this fpga
    logic              rwait;           // merged wait flag
    logic [ADDR_W-1:0] prev_raddr;      // address one cycle ago

    // ----------------------------------------------------------
    // region select
    // ----------------------------------------------------------
    // wait 0 means data in the address cycle, 1 means one cycle later
    assign {int_rdata, int_rwait} = rd_hub  ? {hub_rdata, 1'b1}  :
                                    rd_main ? {main_rdata, 1'b0} :
                                    {{DATA_W{1'b0}}, 1'b0};     // unmapped region

    assign reg_rdata = int_rdata | reg_rdata_ext;
    assign rwait     = int_rwait | reg_rwait_ext;

    // ----------------------------------------------------------
    // valid flag
    // ----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prev_raddr <= '0;
        end
        else
        begin
            prev_raddr <= reg_raddr;
        end
    end

    // a stable address has had its wait cycle
    assign reg_rvalid = ~rwait | (reg_raddr == prev_raddr);

endmodule

// File: run.sh
#!/bin/sh
# builds the host bus testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module host_bus_tb -f flist.f -o host_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/host_bus_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "STATUS: PASS"
exit $?
